//--- hdl/requant_pkg.sv
package requant_pkg;

  ////////////////////
  // array geometry
  ////////////////////

  // 4 columns, 2 pixels per pe
  localparam int COLUMN_NUM   = 4;
  localparam int PE_PIXEL     = 2;
  // pixels carried per channel in one row
  localparam int LANES_PER_CH = COLUMN_NUM * PE_PIXEL;
  // 1x8 mode packs two output channels per row
  localparam int CHAN_NUM     = 2;
  localparam int LANE_NUM     = CHAN_NUM * LANES_PER_CH;

  // pixel widths, 16 bit data plus 8 bit headroom in 8x8
  localparam int PIXEL_W_88   = 24;
  localparam int PIXEL_W_18   = 16;
  localparam int ROW_W        = CHAN_NUM * LANES_PER_CH * PIXEL_W_18;
  localparam int PAD_88_W     = ROW_W - LANES_PER_CH * PIXEL_W_88;

  // per channel scale = tail * 2^-rank
  localparam int TAIL_W       = 16;
  localparam int RANK_W       = 8;

  // multiplier operand and product widths
  localparam int MULT_A_W     = 24;
  localparam int MULT_B_W     = 16;
  localparam int MULT_P_W     = 40;
  // relu looks at the top bit of the meaningful product
  localparam int SIGN_BIT_88  = 39;
  localparam int SIGN_BIT_18  = 31;

  localparam int QUANT_W      = 8;

  // scale table and flow control
  localparam int TABLE_DEPTH  = 16;
  localparam int IDX_W        = 4;
  localparam int QUEUE_DEPTH  = 4;
  localparam int DOWN_CREDITS = 2;
  localparam int QPTR_W       = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W       = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_W       = $clog2(DOWN_CREDITS + 1);

  ////////////////////
  // row and lane types
  ////////////////////

  // one accumulator row, read as 8x8 or as 1x8
  typedef union packed {
    struct packed {
      logic [PAD_88_W-1:0]                     pad;
      logic [LANES_PER_CH-1:0][PIXEL_W_88-1:0] pix;
    } px88;
    // channel 0 sits in the low half
    logic [CHAN_NUM-1:0][LANES_PER_CH-1:0][PIXEL_W_18-1:0] px18;
  } pixel_row_u;

  typedef struct packed {
    logic [CHAN_NUM-1:0][RANK_W-1:0] rank;
    logic [CHAN_NUM-1:0][TAIL_W-1:0] tail;
  } scale_set_t;

  typedef struct packed {
    logic             we;
    logic [IDX_W-1:0] index;
    scale_set_t       set;
  } scale_cfg_t;

  typedef struct packed {
    logic             valid;
    logic [IDX_W-1:0] chan_idx;
    pixel_row_u       row;
  } row_in_t;

  typedef logic [LANE_NUM-1:0][MULT_A_W-1:0] mult_a_t;
  typedef logic [LANE_NUM-1:0][MULT_B_W-1:0] mult_b_t;
  typedef logic [LANE_NUM-1:0][MULT_P_W-1:0] mult_p_t;
  typedef logic [LANE_NUM-1:0][QUANT_W-1:0]  quant_row_t;

endpackage

//--- hdl/scale_fetch.sv
`timescale 1ns/1ps

module scale_fetch (
  input  logic                   clk,
  input  logic                   e_tail_reset,
  input  requant_pkg::scale_cfg_t cfg,
  input  requant_pkg::row_in_t    row_in,
  output requant_pkg::scale_set_t cur_set,
  output requant_pkg::row_in_t    row_q
);
  import requant_pkg::*;

  // one scale set per output channel index
  scale_set_t scale_tab_q [TABLE_DEPTH];

  // cycle 0 copy of the incoming row
  logic             valid_q;
  logic [IDX_W-1:0] idx_q;
  pixel_row_u       pix_q;

  ////////////////////
  // scale table
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      for (int i = 0; i < TABLE_DEPTH; i++)
      begin
        scale_tab_q[i] <= '0;
      end
    end
    else if (cfg.we)
    begin
      scale_tab_q[cfg.index] <= cfg.set;
    end
  end

  // cycle -1 lookup, e_scale registers it next to the row
  assign cur_set = scale_tab_q[row_in.chan_idx];

  ////////////////////
  // cycle -1 to 0 row stage
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= row_in.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    idx_q <= row_in.chan_idx;
    pix_q <= row_in.row;
  end

  assign row_q.valid    = valid_q;
  assign row_q.chan_idx = idx_q;
  assign row_q.row      = pix_q;

  // host must not rewrite the entry a row is reading in the same cycle
  a_no_cfg_read_clash: assert property (@(posedge clk) disable iff (e_tail_reset)
    !(cfg.we && row_in.valid && (cfg.index == row_in.chan_idx)));

endmodule

//--- hdl/e_scale.sv
`timescale 1ns/1ps

module e_scale (
  input  logic                    clk,
  input  logic                    e_tail_reset,
  input  logic                    mode,
  input  requant_pkg::scale_set_t cur_set,
  input  requant_pkg::row_in_t    row_q,
  output requant_pkg::mult_a_t    mult_a,
  output requant_pkg::mult_b_t    mult_b,
  input  requant_pkg::mult_p_t    prod,
  output requant_pkg::quant_row_t quant
);
  import requant_pkg::*;

  // tail meets the row at cycle 0
  logic [CHAN_NUM-1:0][TAIL_W-1:0] tail_q;
  // rank meets the product at cycle 1
  logic [CHAN_NUM-1:0][RANK_W-1:0] rank_d1_q;
  logic [CHAN_NUM-1:0][RANK_W-1:0] rank_q;

  ////////////////////
  // scale set delay
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      tail_q    <= '0;
      rank_d1_q <= '0;
      rank_q    <= '0;
    end
    else
    begin
      tail_q    <= cur_set.tail;
      rank_d1_q <= cur_set.rank;
      rank_q    <= rank_d1_q;
    end
  end

  ////////////////////
  // cycle 0 operands
  ////////////////////

  always_comb
  begin
    for (int i = 0; i < LANES_PER_CH; i++)
    begin
      // low lanes: 8x8 pixel or channel 0 pixel, both zero extended
      if (mode)
        mult_a[i] = MULT_A_W'(row_q.row.px18[0][i]);
      else
        mult_a[i] = MULT_A_W'(row_q.row.px88.pix[i]);
      mult_b[i] = MULT_B_W'(tail_q[0]);
      // high lanes only carry channel 1 in 1x8
      mult_a[LANES_PER_CH + i] = mode ? MULT_A_W'(row_q.row.px18[1][i]) : '0;
      mult_b[LANES_PER_CH + i] = mode ? MULT_B_W'(tail_q[1]) : '0;
    end
  end

  ////////////////////
  // cycle 1 relu, shift, truncate
  ////////////////////

  always_comb
  begin : quant_blk
    logic [RANK_W-1:0]   lane_rank;
    logic                relu_neg;
    logic [MULT_P_W-1:0] body;
    logic [MULT_P_W-1:0] shifted;
    for (int i = 0; i < LANE_NUM; i++)
    begin
      lane_rank = (i < LANES_PER_CH) ? rank_q[0] : rank_q[1];
      if (mode)
      begin
        // 16 bit pixel times 16 bit tail, 32 bit product
        relu_neg = prod[i][SIGN_BIT_18];
        body     = MULT_P_W'(prod[i][SIGN_BIT_18:0]);
      end
      else
      begin
        relu_neg = prod[i][SIGN_BIT_88];
        body     = prod[i][SIGN_BIT_88:0];
      end
      shifted = body >> lane_rank;
      // no saturation, keep the low byte only
      if (relu_neg || (!mode && (i >= LANES_PER_CH)))
        quant[i] = '0;
      else
        quant[i] = shifted[QUANT_W-1:0];
    end
  end

  // mode must hold while a row moves from operands to products
  a_mode_stable: assert property (@(posedge clk) disable iff (e_tail_reset)
    row_q.valid |=> $stable(mode));

endmodule

//--- hdl/scale_mult_array.sv
`timescale 1ns/1ps

module scale_mult_array (
  input  logic                 clk,
  input  logic                 e_tail_reset,
  input  requant_pkg::mult_a_t mult_a,
  input  requant_pkg::mult_b_t mult_b,
  input  logic                 in_valid,
  output requant_pkg::mult_p_t prod,
  output logic                 prod_valid
);
  import requant_pkg::*;

  ////////////////////
  // product registers
  ////////////////////

  // unsigned 24x16, full 40 bit result per lane
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < LANE_NUM; i++)
    begin
      prod[i] <= MULT_P_W'(mult_a[i]) * MULT_P_W'(mult_b[i]);
    end
  end

  ////////////////////
  // row valid alongside
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      prod_valid <= 1'b0;
    end
    else
    begin
      prod_valid <= in_valid;
    end
  end

endmodule

//--- hdl/row_credit_queue.sv
`timescale 1ns/1ps

module row_credit_queue (
  input  logic                    clk,
  input  logic                    e_tail_reset,
  input  logic                    wr_valid,
  input  requant_pkg::quant_row_t wr_row,
  input  logic                    out_credit,
  output requant_pkg::quant_row_t row_out,
  output logic                    out_valid,
  output logic                    in_credit
);
  import requant_pkg::*;

  quant_row_t        mem_q [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr_q;
  logic [QPTR_W-1:0] rd_ptr_q;
  logic [QCNT_W-1:0] count_q;
  // credits left at the downstream consumer
  logic [CRED_W-1:0] credit_q;
  logic              send;

  // pop the head when there is a row and room downstream
  assign send = (count_q != '0) && (credit_q != '0);

  ////////////////////
  // control state
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      credit_q  <= CRED_W'(DOWN_CREDITS);
      out_valid <= 1'b0;
    end
    else
    begin
      if (wr_valid)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (send)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q   <= count_q + QCNT_W'(wr_valid) - QCNT_W'(send);
      credit_q  <= credit_q + CRED_W'(out_credit) - CRED_W'(send);
      out_valid <= send;
    end
  end

  // every row leaving frees one slot upstream
  assign in_credit = out_valid;

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (wr_valid)
      mem_q[wr_ptr_q] <= wr_row;
    if (send)
      row_out <= mem_q[rd_ptr_q];
  end

  // upstream credit keeps the queue from overflowing
  a_no_write_full: assert property (@(posedge clk) disable iff (e_tail_reset)
    wr_valid |-> (count_q != QCNT_W'(QUEUE_DEPTH)));
  // downstream never returns more than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (e_tail_reset)
    credit_q <= CRED_W'(DOWN_CREDITS));

endmodule

//--- hdl/requant_top.sv
`timescale 1ns/1ps

module requant_top (
  input  logic                    clk,
  input  logic                    e_tail_reset,
  // 0 is 8x8, 1 is 1x8, changed only with the pipeline empty
  input  logic                    mode,
  input  requant_pkg::scale_cfg_t cfg,
  input  requant_pkg::row_in_t    row_in,
  output logic                    in_credit,
  output requant_pkg::quant_row_t row_out,
  output logic                    out_valid,
  input  logic                    out_credit
);
  import requant_pkg::*;

  // cycle -1 scale lookup and cycle 0 row
  scale_set_t cur_set;
  row_in_t    row_q;
  // cycle 0 operands, cycle 1 products
  mult_a_t    mult_a;
  mult_b_t    mult_b;
  mult_p_t    prod;
  logic       prod_valid;
  quant_row_t quant;

  scale_fetch scale_fetch_i (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .cfg          (cfg),
    .row_in       (row_in),
    .cur_set      (cur_set),
    .row_q        (row_q)
  );

  e_scale e_scale_i (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .mode         (mode),
    .cur_set      (cur_set),
    .row_q        (row_q),
    .mult_a       (mult_a),
    .mult_b       (mult_b),
    .prod         (prod),
    .quant        (quant)
  );

  scale_mult_array scale_mult_array_i (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .mult_a       (mult_a),
    .mult_b       (mult_b),
    .in_valid     (row_q.valid),
    .prod         (prod),
    .prod_valid   (prod_valid)
  );

  // quantized row lands here two edges after it was accepted
  row_credit_queue row_credit_queue_i (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .wr_valid     (prod_valid),
    .wr_row       (quant),
    .out_credit   (out_credit),
    .row_out      (row_out),
    .out_valid    (out_valid),
    .in_credit    (in_credit)
  );

endmodule

//--- tests/requant_model.svh
`ifndef REQUANT_MODEL_SVH
`define REQUANT_MODEL_SVH

// shadow of the scale table, follows every cfg write the testbench drives
scale_set_t model_tab [TABLE_DEPTH];

// one lane: unsigned product, relu on the precision's top bit, shift, low byte
function automatic logic [QUANT_W-1:0] expect_lane(input logic m, input logic [23:0] pix,
                                                   input logic [15:0] tail,
                                                   input logic [7:0] rank);
  logic [63:0] p;
  logic [63:0] v;
  // 16x16 stays below 2^32 and 24x16 below 2^40, so no masking is needed
  p = {40'd0, pix} * {48'd0, tail};
  if (m ? p[31] : p[39])
    return '0;
  v = p >> rank;
  return v[7:0];
endfunction

// full row, channel 1 lanes stay zero in 8x8
function automatic quant_row_t expect_row(input logic m, input pixel_row_u r,
                                          input scale_set_t s);
  quant_row_t q;
  q = '0;
  for (int j = 0; j < LANES_PER_CH; j++)
  begin
    if (m)
    begin
      q[j] = expect_lane(1'b1, {8'd0, r.px18[0][j]}, s.tail[0], s.rank[0]);
      q[LANES_PER_CH + j] = expect_lane(1'b1, {8'd0, r.px18[1][j]}, s.tail[1], s.rank[1]);
    end
    else
      q[j] = expect_lane(1'b0, r.px88.pix[j], s.tail[0], s.rank[0]);
  end
  return q;
endfunction

`endif

//--- tests/tb_requant_top.sv
`timescale 1ns/1ps

module tb_requant_top;
  import requant_pkg::*;
  `include "requant_model.svh"

  localparam int ROWS_PER_MODE  = 300;
  // 40 cycles per row over both modes, plus reset
  localparam int TIMEOUT_CYCLES = 40 * 2 * ROWS_PER_MODE + 10;

  logic       clk;
  logic       e_tail_reset;
  logic       mode;
  scale_cfg_t cfg;
  row_in_t    row_in;
  logic       in_credit;
  quant_row_t row_out;
  logic       out_valid;
  logic       out_credit;

  logic [31:0] lfsr_state;
  int          cycle;
  // upstream credits held, downstream credits granted but unused
  int          up_credits;
  int          down_avail;
  int          gap_left;
  int          rows_sent;
  int          rows_got;
  int          credits_back;
  int          row_target;
  quant_row_t  exp_q [$];
  // cycle at which each consumed row hands its credit back
  int          ret_due [$];
  // earliest cycle each accepted row can show on out_valid
  int          ready_due [$];
  // cycle from which each returned credit can release a row
  int          cred_due [$];
  // downstream credits the queue can spend
  int          queue_credits;

  requant_top requant_top_i (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .mode         (mode),
    .cfg          (cfg),
    .row_in       (row_in),
    .in_credit    (in_credit),
    .row_out      (row_out),
    .out_valid    (out_valid),
    .out_credit   (out_credit)
  );

  always #5 clk = ~clk;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk)
  begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES)
      fail_now("timeout: rows still outstanding when the cycle limit was reached");
  end

  ////////////////////
  // random source
  ////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hD0000001;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // mostly the corner ranks, sometimes anything up to 63
  function automatic logic [RANK_W-1:0] rand_rank();
    logic [2:0] sel;
    sel = 3'(take_bits(3));
    case (sel)
      3'd0: return 8'd0;
      3'd1: return 8'd8;
      3'd2: return 8'd16;
      3'd3: return 8'd31;
      3'd4: return 8'd39;
      default: return RANK_W'(take_bits(6));
    endcase
  endfunction

  function automatic scale_set_t rand_set();
    scale_set_t s;
    for (int c = 0; c < CHAN_NUM; c++)
    begin
      s.tail[c] = TAIL_W'(take_bits(TAIL_W));
      // high tails push products into the relu bit
      if (take_bits(1) != 0)
        s.tail[c] = s.tail[c] | 16'hC000;
      s.rank[c] = rand_rank();
    end
    return s;
  endfunction

  function automatic pixel_row_u rand_row(input logic m);
    pixel_row_u r;
    logic       bias;
    r = '0;
    bias = (take_bits(2) == 0);
    for (int j = 0; j < LANES_PER_CH; j++)
    begin
      if (m)
      begin
        for (int c = 0; c < CHAN_NUM; c++)
        begin
          r.px18[c][j] = 16'(take_bits(16));
          if (bias && take_bits(1) != 0)
            r.px18[c][j] = r.px18[c][j] | 16'hC000;
        end
      end
      else
      begin
        r.px88.pix[j] = 24'(take_bits(24));
        if (bias && take_bits(1) != 0)
          r.px88.pix[j] = r.px88.pix[j] | 24'hC00000;
      end
    end
    return r;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_row(input quant_row_t exp, input quant_row_t act);
    if (act !== exp)
      fail_now($sformatf("ERR row_out exp=%h act=%h", exp, act));
  endtask

  task automatic check_credit(input logic exp, input logic act);
    if (act !== exp)
      fail_now($sformatf("ERR in_credit exp=%h act=%h", exp, act));
  endtask

  ////////////////////
  // one clock of traffic
  ////////////////////

  task automatic run_cycle(input logic allow_rows);
    row_in_t    nxt_row;
    scale_cfg_t nxt_cfg;
    quant_row_t exp_row;
    logic       exp_send;
    @(negedge clk);
    // a returned credit reaches the queue count one edge after it is driven
    while (cred_due.size() != 0 && cred_due[0] <= cycle)
    begin
      void'(cred_due.pop_front());
      queue_credits++;
    end
    // head row leaves as soon as it is stored and a credit is there
    exp_send = (ready_due.size() != 0) && (ready_due[0] <= cycle) && (queue_credits > 0);
    // outputs settled after the rising edge
    if (out_valid !== exp_send)
      fail_now($sformatf("ERR out_valid exp=%h act=%h", exp_send, out_valid));
    check_credit(exp_send, in_credit);
    if (exp_send)
    begin
      void'(ready_due.pop_front());
      queue_credits--;
    end
    if (in_credit)
    begin
      up_credits++;
      credits_back++;
      if (up_credits > QUEUE_DEPTH)
        fail_now("upstream got back more credits than the queue depth");
    end
    if (out_valid)
    begin
      down_avail--;
      if (down_avail < 0)
        fail_now("row sent without a downstream credit");
      if (exp_q.size() == 0)
        fail_now("output row appeared with no row outstanding");
      exp_row = exp_q.pop_front();
      check_row(exp_row, row_out);
      rows_got++;
      ret_due.push_back(cycle + int'(take_bits(2)));
    end
    // consumer side, with long stalls now and then
    out_credit = 1'b0;
    if (gap_left > 0)
      gap_left--;
    else if (take_bits(6) == 0)
      gap_left = 20 + int'(take_bits(4));
    else if (ret_due.size() != 0 && ret_due[0] <= cycle)
    begin
      void'(ret_due.pop_front());
      out_credit = 1'b1;
      down_avail++;
      cred_due.push_back(cycle + 2);
    end
    // upstream sends only while holding a credit
    nxt_row = '0;
    if (allow_rows && up_credits > 0 && rows_sent < row_target && take_bits(2) != 0)
    begin
      nxt_row.valid    = 1'b1;
      nxt_row.chan_idx = IDX_W'(take_bits(IDX_W));
      nxt_row.row      = rand_row(mode);
      exp_q.push_back(expect_row(mode, nxt_row.row, model_tab[nxt_row.chan_idx]));
      // accepted next edge, stored two edges later, shown one edge after that
      ready_due.push_back(cycle + 4);
      up_credits--;
      rows_sent++;
    end
    // table rewrite, never to the index being read
    nxt_cfg = '0;
    if (take_bits(2) == 0)
    begin
      nxt_cfg.we    = 1'b1;
      nxt_cfg.index = IDX_W'(take_bits(IDX_W));
      if (nxt_row.valid && nxt_cfg.index == nxt_row.chan_idx)
        nxt_cfg.index = nxt_cfg.index ^ IDX_W'(1);
      nxt_cfg.set = rand_set();
      model_tab[nxt_cfg.index] = nxt_cfg.set;
    end
    row_in = nxt_row;
    cfg    = nxt_cfg;
  endtask

  initial
  begin
    lfsr_state    = 32'd87198;
    cycle         = 0;
    up_credits    = QUEUE_DEPTH;
    down_avail    = DOWN_CREDITS;
    queue_credits = DOWN_CREDITS;
    gap_left      = 0;
    rows_sent     = 0;
    rows_got      = 0;
    credits_back  = 0;
    row_target    = 0;
    for (int i = 0; i < TABLE_DEPTH; i++)
      model_tab[i] = '0;
    clk          = 1'b0;
    e_tail_reset = 1'b1;
    mode         = 1'b0;
    cfg          = '0;
    row_in       = '0;
    out_credit   = 1'b0;
    repeat (10) @(negedge clk);
    e_tail_reset = 1'b0;
    // 8x8 rows
    row_target = ROWS_PER_MODE;
    while (rows_sent < row_target)
      run_cycle(1'b1);
    while (exp_q.size() != 0)
      run_cycle(1'b0);
    // pipeline empty, switch to 1x8
    mode = 1'b1;
    row_target = 2 * ROWS_PER_MODE;
    while (rows_sent < row_target)
      run_cycle(1'b1);
    while (exp_q.size() != 0)
      run_cycle(1'b0);
    if (rows_got != 2 * ROWS_PER_MODE || credits_back != 2 * ROWS_PER_MODE ||
        up_credits != QUEUE_DEPTH)
      fail_now("row or credit totals do not match the rows sent");
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- files.f
+incdir+tests
hdl/requant_pkg.sv
hdl/scale_fetch.sv
hdl/e_scale.sv
hdl/scale_mult_array.sv
hdl/row_credit_queue.sv
hdl/requant_top.sv
tests/tb_requant_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with the RTL, run it, and look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_requant_top -f files.f -o sim_requant \
  && ./obj_dir/sim_requant | tee /dev/stderr | grep "NO ERRORS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
